/* bp_defines.svh */
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// global history length in bits
`define GH_WIDTH    16

// branches that may be in flight between predict and resolve
`define CKPT_DEPTH  16

// one bit wider than the queue index so full and empty differ
`define CKPT_PTR_W  5

// fetch address width
`define PC_WIDTH    32

// counter table index bits (1024 entries)
// index = pc[PHT_IDX_W+1:2] ^ ghist[PHT_IDX_W-1:0]
`define PHT_IDX_W   10

`endif

/* bp_if.sv */
`timescale 1ns/1ps
`include "bp_defines.svh"

// combinational lookup path from the history unit into the counter table
interface lookup_if;
    logic [`PC_WIDTH-1:0] pc;
    logic [`GH_WIDTH-1:0] ghist;  // speculative history
    logic                 taken;  // counter guess

    modport source (
        output pc,
        output ghist,
        input  taken
    );

    modport tbl (
        input  pc,
        input  ghist,
        output taken
    );
endinterface

// counter update request for each resolved branch
interface train_if;
    logic                 valid;
    logic [`PC_WIDTH-1:0] pc;
    logic [`GH_WIDTH-1:0] ghist;    // history seen at predict time
    logic                 outcome;  // actual direction

    modport source (
        output valid,
        output pc,
        output ghist,
        output outcome
    );

    modport sink (
        input valid,
        input pc,
        input ghist,
        input outcome
    );
endinterface

/* bp_pkg.sv */
package bp_pkg;

    // 2-bit saturating counter that predicts taken when msb set
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_state_e;

    // what the history unit does to ghist and the queue this cycle
    typedef enum logic [1:0] {
        gh_hold    = 2'b00,  // nothing happens
        gh_push    = 2'b01,  // predict only
        gh_retire  = 2'b10,  // correct resolve with an optional predict
        gh_recover = 2'b11   // mispredict rebuilds history and flushes
    } gh_action_e;

endpackage

/* ghr_ckpt.sv */
`timescale 1ns/1ps
`include "bp_defines.svh"

module ghr_ckpt (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 pred_valid,
    input  logic [`PC_WIDTH-1:0] pred_pc,
    output logic                 pred_ready,
    input  logic                 res_valid,
    input  logic                 res_taken,
    input  logic [`PC_WIDTH-1:0] res_pc,
    output logic                 res_mispredict,
    lookup_if.source             lk,
    train_if.source              tr
);
    import bp_pkg::*;

    logic [`GH_WIDTH-1:0]   ghist;
    logic [`GH_WIDTH-1:0]   ckpt_gh [`CKPT_DEPTH];     // history before each predict
    logic                   ckpt_guess [`CKPT_DEPTH];  // guess made for it
    logic [`CKPT_PTR_W-1:0] head_ptr;                  // oldest entry
    logic [`CKPT_PTR_W-1:0] tail_ptr;                  // next free slot
    logic [`CKPT_PTR_W-1:0] used;
    logic [`CKPT_PTR_W-2:0] head_idx;
    logic [`CKPT_PTR_W-2:0] tail_idx;
    logic                   q_empty;
    logic                   q_full;
    logic [`GH_WIDTH-1:0]   old_gh;
    logic                   old_guess;
    logic                   res_live;
    logic                   pred_fire;
    logic                   push_en;
    logic                   guess;
    gh_action_e             action;

    assign head_idx = head_ptr[`CKPT_PTR_W-2:0];
    assign tail_idx = tail_ptr[`CKPT_PTR_W-2:0];
    assign used     = tail_ptr - head_ptr;
    assign q_empty  = (head_ptr == tail_ptr);
    assign q_full   = (used == `CKPT_PTR_W'(`CKPT_DEPTH));

    assign old_gh    = ckpt_gh[head_idx];
    assign old_guess = ckpt_guess[head_idx];

    // lookup uses the live speculative history
    assign lk.pc    = pred_pc;
    assign lk.ghist = ghist;
    assign guess    = lk.taken;

    assign res_live       = res_valid && !q_empty;
    assign res_mispredict = res_live && (res_taken != old_guess);
    assign pred_ready     = !q_full && !res_mispredict;  // stall fetch while flushing
    assign pred_fire      = pred_valid && pred_ready;

    always_comb begin
        if (res_mispredict) begin
            action = gh_recover;
        end else if (res_live) begin
            action = gh_retire;
        end else if (pred_fire) begin
            action = gh_push;
        end else begin
            action = gh_hold;
        end
    end

    assign push_en = pred_fire;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ghist    <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            case (action)
                gh_recover: begin
                    ghist    <= {old_gh[`GH_WIDTH-2:0], res_taken};  // actual outcome
                    head_ptr <= '0;
                    tail_ptr <= '0;
                end
                gh_retire: begin
                    head_ptr <= head_ptr + `CKPT_PTR_W'(1);
                    if (push_en) begin
                        ghist    <= {ghist[`GH_WIDTH-2:0], guess};
                        tail_ptr <= tail_ptr + `CKPT_PTR_W'(1);
                    end
                end
                gh_push: begin
                    ghist    <= {ghist[`GH_WIDTH-2:0], guess};
                    tail_ptr <= tail_ptr + `CKPT_PTR_W'(1);
                end
                default: begin
                    ghist <= ghist;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            ckpt_gh[tail_idx]    <= ghist;
            ckpt_guess[tail_idx] <= guess;
        end
    end

    // every resolve trains the counter whether right or wrong
    assign tr.valid   = res_live;
    assign tr.pc      = res_pc;
    assign tr.ghist   = old_gh;
    assign tr.outcome = res_taken;

endmodule

/* gshare_top.sv */
`timescale 1ns/1ps
`include "bp_defines.svh"

module gshare_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 pred_valid,
    input  logic [`PC_WIDTH-1:0] pred_pc,
    output logic                 pred_ready,
    output logic                 pred_taken,
    output logic [`GH_WIDTH-1:0] pred_ghist,
    input  logic                 res_valid,
    input  logic [`PC_WIDTH-1:0] res_pc,
    input  logic                 res_taken,
    output logic                 res_mispredict
);

    lookup_if lk_if ();
    train_if  tr_if ();

    ghr_ckpt u_ghr_ckpt (
        .clk            (clk),
        .rstn           (rstn),
        .pred_valid     (pred_valid),
        .pred_pc        (pred_pc),
        .pred_ready     (pred_ready),
        .res_valid      (res_valid),
        .res_taken      (res_taken),
        .res_pc         (res_pc),
        .res_mispredict (res_mispredict),
        .lk             (lk_if.source),
        .tr             (tr_if.source)
    );

    pht u_pht (
        .clk  (clk),
        .rstn (rstn),
        .lk   (lk_if.tbl),
        .tr   (tr_if.sink)
    );

    // same-cycle guess and the history it was made with
    assign pred_taken = lk_if.taken;
    assign pred_ghist = lk_if.ghist;

endmodule

/* pht.sv */
`timescale 1ns/1ps
`include "bp_defines.svh"

module pht (
    input  logic    clk,
    input  logic    rstn,
    lookup_if.tbl   lk,
    train_if.sink   tr
);
    import bp_pkg::*;

    ctr_state_e             ctr [1 << `PHT_IDX_W];
    logic [`PHT_IDX_W-1:0]  lk_idx;
    logic [`PHT_IDX_W-1:0]  tr_idx;
    ctr_state_e             lk_state;
    ctr_state_e             tr_state;

    // step toward the outcome and saturate at both ends
    function automatic ctr_state_e ctr_step(input ctr_state_e s, input logic t);
        case (s)
            strong_nt: ctr_step = t ? weak_nt  : strong_nt;
            weak_nt:   ctr_step = t ? weak_t   : strong_nt;
            weak_t:    ctr_step = t ? strong_t : weak_nt;
            default:   ctr_step = t ? strong_t : weak_t;
        endcase
    endfunction

    // gshare index from word-aligned pc xor history
    assign lk_idx = lk.pc[`PHT_IDX_W+1:2] ^ lk.ghist[`PHT_IDX_W-1:0];
    assign tr_idx = tr.pc[`PHT_IDX_W+1:2] ^ tr.ghist[`PHT_IDX_W-1:0];

    assign lk_state = ctr[lk_idx];
    assign tr_state = ctr[tr_idx];

    assign lk.taken = (lk_state == weak_t) || (lk_state == strong_t);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < (1 << `PHT_IDX_W); i++) begin
                ctr[i] <= weak_nt;  // start weakly not-taken
            end
        end else if (tr.valid) begin
            ctr[tr_idx] <= ctr_step(tr_state, tr.outcome);
        end
    end

endmodule

/* run.sh */
#!/bin/bash
# compile with verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_top \
    -f src.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* src.f */
+incdir+.
bp_pkg.sv
bp_if.sv
ghr_ckpt.sv
pht.sv
gshare_top.sv
tb_checker.sv
tb_top.sv

/* tb_checker.sv */
`timescale 1ns/1ps
`include "bp_defines.svh"

module tb_checker (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 pred_valid,
    input  logic [`PC_WIDTH-1:0] pred_pc,
    input  logic                 pred_ready,
    input  logic                 pred_taken,
    input  logic [`GH_WIDTH-1:0] pred_ghist,
    input  logic                 res_valid,
    input  logic [`PC_WIDTH-1:0] res_pc,
    input  logic                 res_taken,
    input  logic                 res_mispredict,
    input  int                   phase,
    output int                   err_count,
    output int                   check_count,
    output int                   tests_run,
    output int                   tests_failed
);
    import bp_pkg::*;

    logic [1:0]           ctr_m [1 << `PHT_IDX_W];  // model counters
    logic [`GH_WIDTH-1:0] gh_m;                     // model speculative history
    logic [`PC_WIDTH-1:0] q_pc [$];
    logic [`GH_WIDTH-1:0] q_gh [$];
    logic                 q_guess [$];
    logic                 prev_stall = 1'b0;
    logic [`PC_WIDTH-1:0] prev_pc = '0;
    int cur_phase = 0;
    int ph_checks = 0;
    int ph_errs   = 0;
    int n_err     = 0;
    int n_checks  = 0;
    int n_tests   = 0;
    int n_failed  = 0;

    assign err_count    = n_err;
    assign check_count  = n_checks;
    assign tests_run    = n_tests;
    assign tests_failed = n_failed;

    function automatic string phase_name(input int p);
        case (p)
            1: return "after reset";
            2: return "predict bursts";
            3: return "queue full stall";
            4: return "correct resolves";
            5: return "mispredict recovery";
            default: return "random mix";
        endcase
    endfunction

    // gshare index from word pc bits xor low history bits
    function automatic logic [`PHT_IDX_W-1:0] table_index(input logic [`PC_WIDTH-1:0] pc,
                                                          input logic [`GH_WIDTH-1:0] gh);
        return pc[`PHT_IDX_W+1:2] ^ gh[`PHT_IDX_W-1:0];
    endfunction

    function automatic logic model_guess(input logic [`PC_WIDTH-1:0] pc,
                                         input logic [`GH_WIDTH-1:0] gh);
        return ctr_m[table_index(pc, gh)] >= weak_t;
    endfunction

    task automatic train(input logic [`PC_WIDTH-1:0] pc, input logic [`GH_WIDTH-1:0] gh,
                         input logic t);
        logic [`PHT_IDX_W-1:0] i;
        i = table_index(pc, gh);
        if (t && ctr_m[i] != strong_t) begin
            ctr_m[i] = ctr_m[i] + 2'd1;
        end else if (!t && ctr_m[i] != strong_nt) begin
            ctr_m[i] = ctr_m[i] - 2'd1;
        end
    endtask

    task automatic expect_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        ph_checks++;
        if (got !== exp) begin
            $display("ERR @%0t: %s is %0h, expected %0h", $time, what, got, exp);
            n_err++;
            ph_errs++;
        end
    endtask

    task automatic protocol_fail(input string msg);
        $display("stimulus error at %0t ns: %s", $time, msg);
        n_err++;
        ph_errs++;
    endtask

    task automatic reset_model();
        gh_m = '0;
        q_pc.delete();
        q_gh.delete();
        q_guess.delete();
        prev_stall = 1'b0;
        for (int i = 0; i < (1 << `PHT_IDX_W); i++) begin
            ctr_m[i] = weak_nt;
        end
    endtask

    // compare this cycle and then step the model to the state after the next edge
    task automatic check_and_advance();
        logic exp_misp;
        logic exp_ready;
        logic guess;
        logic fire;
        exp_misp = 1'b0;
        if (res_valid && q_pc.size() == 0) begin
            protocol_fail("resolve sent with no branch in flight");
        end else if (res_valid) begin
            exp_misp = (res_taken != q_guess[0]);
            if (res_pc != q_pc[0]) begin
                protocol_fail("resolve does not name the oldest branch");
            end
        end
        if (prev_stall && (!pred_valid || pred_pc != prev_pc)) begin
            protocol_fail("fetch dropped or changed a stalled branch");
        end
        exp_ready = (q_pc.size() < `CKPT_DEPTH) && !exp_misp;
        guess     = model_guess(pred_pc, gh_m);  // counters before training
        expect_val("pred_ready", 32'(pred_ready), 32'(exp_ready));
        expect_val("res_mispredict", 32'(res_mispredict), 32'(exp_misp));
        expect_val("pred_ghist", 32'(pred_ghist), 32'(gh_m));
        if (pred_valid) begin
            expect_val("pred_taken", 32'(pred_taken), 32'(guess));
        end
        fire       = pred_valid && exp_ready;
        prev_stall = pred_valid && !exp_ready;
        prev_pc    = pred_pc;
        if (exp_misp) begin
            train(res_pc, q_gh[0], res_taken);
            gh_m = {q_gh[0][`GH_WIDTH-2:0], res_taken};
            q_pc.delete();
            q_gh.delete();
            q_guess.delete();
        end else begin
            if (res_valid && q_pc.size() > 0) begin
                train(res_pc, q_gh[0], res_taken);
                void'(q_pc.pop_front());
                void'(q_gh.pop_front());
                void'(q_guess.pop_front());
            end
            if (fire) begin
                q_pc.push_back(pred_pc);
                q_gh.push_back(gh_m);
                q_guess.push_back(guess);
                gh_m = {gh_m[`GH_WIDTH-2:0], guess};
            end
        end
    endtask

    always @(negedge clk) begin
        if (phase != cur_phase) begin
            if (cur_phase > 0 && cur_phase < 7) begin
                n_tests++;
                if (ph_errs != 0) begin
                    n_failed++;
                end
                $display("test %0d %s: %s, %0d checks, %0d errors", cur_phase,
                         phase_name(cur_phase), (ph_errs == 0) ? "ok" : "fail",
                         ph_checks, ph_errs);
            end
            cur_phase = phase;
            ph_checks = 0;
            ph_errs   = 0;
        end
        if (!rstn) begin
            reset_model();
        end else begin
            check_and_advance();
        end
    end

endmodule

/* tb_top.sv */
`timescale 1ns/1ps
`include "bp_defines.svh"

module tb_top;
    localparam int RST_CYCLES  = 16;
    localparam int LEN_RESET   = 4;
    localparam int LEN_BURST   = 10;
    localparam int LEN_FILL    = 30;
    localparam int LEN_DRAIN   = 40;
    localparam int LEN_TRAIN   = 120;
    localparam int MISP_ROUNDS = 4;
    localparam int LEN_ROUND   = 47;  // 6 + 1 + 20 + 20
    localparam int LEN_RANDOM  = 2000;
    localparam int MAX_CYCLES  = 2 * (LEN_RESET + LEN_BURST + LEN_FILL + LEN_DRAIN
                                      + LEN_TRAIN + MISP_ROUNDS * LEN_ROUND + LEN_RANDOM)
                                 + RST_CYCLES;

    logic                 clk;
    logic                 rstn;
    logic                 pred_valid;
    logic [`PC_WIDTH-1:0] pred_pc;
    logic                 pred_ready;
    logic                 pred_taken;
    logic [`GH_WIDTH-1:0] pred_ghist;
    logic                 res_valid;
    logic [`PC_WIDTH-1:0] res_pc;
    logic                 res_taken;
    logic                 res_mispredict;

    int seed;
    int phase;
    int cycles = 0;
    int err_count;
    int check_count;
    int tests_run;
    int tests_failed;
    logic [`PC_WIDTH-1:0] pc_pool [8];  // small pool so table entries collide
    logic [`PC_WIDTH-1:0] fly_pc [$];   // branches sent and not yet resolved
    logic                 fly_guess [$];

    gshare_top dut_i (
        .clk            (clk),
        .rstn           (rstn),
        .pred_valid     (pred_valid),
        .pred_pc        (pred_pc),
        .pred_ready     (pred_ready),
        .pred_taken     (pred_taken),
        .pred_ghist     (pred_ghist),
        .res_valid      (res_valid),
        .res_pc         (res_pc),
        .res_taken      (res_taken),
        .res_mispredict (res_mispredict)
    );

    tb_checker chk_i (
        .clk            (clk),
        .rstn           (rstn),
        .pred_valid     (pred_valid),
        .pred_pc        (pred_pc),
        .pred_ready     (pred_ready),
        .pred_taken     (pred_taken),
        .pred_ghist     (pred_ghist),
        .res_valid      (res_valid),
        .res_pc         (res_pc),
        .res_taken      (res_taken),
        .res_mispredict (res_mispredict),
        .phase          (phase),
        .err_count      (err_count),
        .check_count    (check_count),
        .tests_run      (tests_run),
        .tests_failed   (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic roll(input int pct);
        return int'({$random(seed)} % 100) < pct;
    endfunction

    // bookkeeping at the falling edge and new inputs at the rising edge
    // r_mode 0 gives a random outcome, 1 agrees with the guess, 2 disagrees
    task automatic run_cycle(input int p_pct, input int r_pct, input int r_mode);
        logic       held;
        logic [2:0] k;
        @(negedge clk);
        if (res_valid) begin
            if (res_mispredict) begin
                fly_pc.delete();  // younger branches are flushed
                fly_guess.delete();
            end else begin
                void'(fly_pc.pop_front());
                void'(fly_guess.pop_front());
            end
        end
        if (pred_valid && pred_ready) begin
            fly_pc.push_back(pred_pc);
            fly_guess.push_back(pred_taken);
        end
        held = pred_valid && !pred_ready;
        @(posedge clk);
        if (!held) begin
            k = 3'($random(seed));
            pred_valid <= roll(p_pct);
            pred_pc    <= pc_pool[k];
        end
        if (fly_pc.size() > 0 && roll(r_pct)) begin
            res_valid <= 1'b1;
            res_pc    <= fly_pc[0];
            case (r_mode)
                0: res_taken <= 1'($random(seed));
                1: res_taken <= fly_guess[0];
                default: res_taken <= !fly_guess[0];
            endcase
        end else begin
            res_valid <= 1'b0;
        end
    endtask

    initial begin
        seed       = 32'hb702;
        phase      = 0;
        rstn       = 1'b0;
        pred_valid = 1'b0;
        pred_pc    = '0;
        res_valid  = 1'b0;
        res_pc     = '0;
        res_taken  = 1'b0;
        for (int i = 0; i < 8; i++) begin
            pc_pool[i] = {20'h00400, 10'($random(seed)), 2'b00};
        end
        repeat (RST_CYCLES) @(posedge clk);
        rstn  <= 1'b1;
        phase <= 1;
        repeat (LEN_RESET) run_cycle(100, 0, 0);
        phase <= 2;
        repeat (LEN_BURST) run_cycle(70, 0, 0);
        phase <= 3;
        repeat (LEN_FILL) run_cycle(100, 0, 0);  // queue fills and ready drops
        repeat (LEN_DRAIN) run_cycle(100, 30, 1);
        phase <= 4;
        repeat (LEN_TRAIN) run_cycle(50, 50, 1);
        phase <= 5;
        repeat (MISP_ROUNDS) begin
            repeat (6) run_cycle(100, 0, 0);
            run_cycle(100, 100, 2);
            repeat (20) run_cycle(100, 0, 0);
            repeat (20) run_cycle(0, 100, 1);
        end
        phase <= 6;
        repeat (LEN_RANDOM) run_cycle(60, 40, 0);
        phase     <= 7;
        res_valid <= 1'b0;
        repeat (2) @(negedge clk);
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0 && tests_failed == 0 && tests_run == 6 && check_count > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
